// ==== build.f ====
design/periph_pkg.sv
design/apb_decoder.sv
design/periph_regs.sv
design/dsp_mult.sv
design/pad_shifter.sv
design/mmio_top.sv
test/tb_mmio.sv

// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --assert
TOP        = tb_mmio
RTL_TOP    = mmio_top
FILELIST   = build.f
PASS_TEXT  = ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

// ==== test/tb_mmio.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the memory-mapped peripheral block
// APB master tasks, LFSR stimulus, reference model
// and directed plus random register tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module tb_mmio;

    logic                    vdp_clk;
    logic                    vdp_reset;
    periph_pkg::apb_req_t    apb_req;
    periph_pkg::apb_rsp_t    apb_rsp;
    periph_pkg::buttons_t    buttons;
    logic [1:0]              leds;
    periph_pkg::flash_pins_t flash_pins;
    logic [3:0]              flash_io_in;

    logic [15:0]             lfsr_q;

    // Reference model state
    logic [1:0]              status_model;
    logic signed [15:0]      mult_a_model;
    logic signed [15:0]      mult_b_model;
    logic [15:0]             pad_model;
    periph_pkg::flash_pins_t flash_model;

    mmio_top dut0 (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp),
        .buttons(buttons),
        .leds(leds),
        .flash_pins(flash_pins),
        .flash_io_in(flash_io_in)
    );

    initial begin
        vdp_clk = 1'b0;
        forever #5 vdp_clk = ~vdp_clk;
    end

    // Galois LFSR over x^16 + x^14 + x^13 + x^11 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_q[0];
            lfsr_q = {1'b0, lfsr_q[15:1]} ^ (b ? 16'hB400 : 16'h0000);
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic logic [7:0] byte_addr(input int word);
        return 8'(word * 4);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge vdp_clk);
            #1;
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic apb_transfer(input string name, input logic wr, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic slverr);
        int cycles;
        apb_req.paddr = addr;
        apb_req.pwrite = wr;
        apb_req.pwdata = wdata;
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge vdp_clk);
        #1;
        apb_req.penable = 1'b1;
        cycles = 1;
        while (!apb_rsp.pready) begin
            if (cycles >= 20) begin
                $display("Timeout: no pready within 20 cycles on %s", name);
                $display("SOME TESTS FAILED");
                $fatal(1, "Transfer never completed");
            end
            @(posedge vdp_clk);
            #1;
            cycles++;
        end
        rdata = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        // Completion edge
        @(posedge vdp_clk);
        cycles++;
        #1;
        apb_req.psel = 1'b0;
        apb_req.penable = 1'b0;
        check_value({name, " cycles"}, 32'd3, 32'(cycles));
    endtask

    task automatic apb_write(input string name, input int word, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        slverr;
        apb_transfer(name, 1'b1, byte_addr(word), data, rdata, slverr);
        check_value({name, " pslverr"}, 32'(exp_err), 32'(slverr));
    endtask

    task automatic apb_read(input string name, input int word, input logic [31:0] exp_data,
                            input logic exp_err);
        logic [31:0] rdata;
        logic        slverr;
        apb_transfer(name, 1'b0, byte_addr(word), take_bits(32), rdata, slverr);
        check_value({name, " pslverr"}, 32'(exp_err), 32'(slverr));
        check_value({name, " prdata"}, exp_data, rdata);
    endtask

    function automatic logic [31:0] model_product();
        logic signed [31:0] p;
        p = 32'(mult_a_model) * 32'(mult_b_model);
        return p;
    endfunction

    function automatic periph_pkg::flash_pins_t flash_expect(input logic [15:0] d);
        periph_pkg::flash_pins_t f;
        if (d[15]) begin
            f.io_out = d[3:0];
            f.io_oe = d[7:4];
            f.clk = d[8];
            f.csn = d[9];
        end else begin
            f = '{clk: 1'b0, csn: 1'b1, io_out: 4'b0, io_oe: 4'b0};
        end
        return f;
    endfunction

    initial begin
        logic [31:0] d;
        logic [2:0]  btn;
        int          word;
        lfsr_q = 16'd68;
        vdp_reset = 1'b1;
        apb_req = '0;
        buttons = '0;
        flash_io_in = 4'b0;
        repeat (16) @(posedge vdp_clk);
        #1;
        vdp_reset = 1'b0;

        // Reset state and status register
        status_model = 2'b01;
        flash_model = flash_expect(16'h0000);
        check_value("reset leds", 32'(status_model), 32'(leds));
        check_value("reset pready", 32'd0, 32'(apb_rsp.pready));
        check_value("reset flash pins", 32'(flash_model), 32'(flash_pins));
        apb_read("reset status", 0, 32'd1, 1'b0);
        for (int i = 0; i < 8; i++) begin
            d = take_bits(32);
            apb_write("status write", 0, d, 1'b0);
            status_model = d[1:0];
            check_value("status leds", 32'(status_model), 32'(leds));
            apb_read("status read", 0, 32'(status_model), 1'b0);
        end

        // Signed multiplier
        for (int i = 0; i < 8; i++) begin
            d = take_bits(32);
            mult_a_model = d[15:0];
            apb_write("mult a write", 1, d, 1'b0);
            d = take_bits(32);
            mult_b_model = d[15:0];
            apb_write("mult b write", 2, d, 1'b0);
            apb_read("product via a", 1, model_product(), 1'b0);
            apb_read("product via b", 2, model_product(), 1'b0);
        end

        // Gamepad latch and shift
        for (int r = 0; r < 3; r++) begin
            btn = 3'(take_bits(3));
            buttons = btn;
            pad_model = '0;
            pad_model[7] = btn[2];
            pad_model[6] = btn[0];
            pad_model[0] = btn[1];
            apb_write("pad latch on", 3, 32'd1, 1'b0);
            apb_write("pad latch off", 3, 32'd0, 1'b0);
            apb_read("pad first bit", 3, {31'b0, pad_model[0]}, 1'b0);
            for (int s = 0; s < 16; s++) begin
                apb_write("pad clk high", 3, 32'd2, 1'b0);
                apb_write("pad clk low", 3, 32'd0, 1'b0);
                pad_model = pad_model >> 1;
                apb_read("pad shifted bit", 3, {31'b0, pad_model[0]}, 1'b0);
            end
        end

        // Flash pins in manual and idle mode
        for (int i = 0; i < 8; i++) begin
            d = take_bits(32);
            d[15] = 1'b1;
            apb_write("flash manual", 4, d, 1'b0);
            flash_model = flash_expect(d[15:0]);
            check_value("flash manual pins", 32'(flash_model), 32'(flash_pins));
            flash_io_in = 4'(take_bits(4));
            idle_cycles(2);
            apb_read("flash input", 4, 32'(flash_io_in), 1'b0);
            d = take_bits(32);
            d[15] = 1'b0;
            apb_write("flash off", 4, d, 1'b0);
            flash_model = flash_expect(d[15:0]);
            check_value("flash idle pins", 32'(flash_model), 32'(flash_pins));
        end

        // Unmapped words with a live flash setup to guard
        d = take_bits(32);
        d[15] = 1'b1;
        apb_write("flash before unmapped", 4, d, 1'b0);
        flash_model = flash_expect(d[15:0]);
        for (int i = 0; i < 8; i++) begin
            word = 5 + int'(take_bits(6) % 59);
            apb_write("unmapped write", word, take_bits(32), 1'b1);
            apb_read("unmapped read", word, 32'd0, 1'b1);
        end
        check_value("leds after unmapped", 32'(status_model), 32'(leds));
        check_value("flash after unmapped", 32'(flash_model), 32'(flash_pins));
        apb_read("status after unmapped", 0, 32'(status_model), 1'b0);
        apb_read("product after unmapped", 1, model_product(), 1'b0);
        apb_read("pad after unmapped", 3, {31'b0, pad_model[0]}, 1'b0);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/mmio_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory-mapped peripheral block top level
// APB decoder, registers, multiplier, pad shifter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module mmio_top (
    input  logic                    vdp_clk,
    input  logic                    vdp_reset,
    input  periph_pkg::apb_req_t    apb_req,
    output periph_pkg::apb_rsp_t    apb_rsp,
    input  periph_pkg::buttons_t    buttons,
    output logic [1:0]              leds,
    output periph_pkg::flash_pins_t flash_pins,
    input  logic [3:0]              flash_io_in
);

    periph_pkg::reg_wr_t           reg_wr;
    logic [1:0]                    status_rd;
    logic [periph_pkg::data_w-1:0] product;
    logic                          pad_bit;
    logic [3:0]                    flash_rd;
    logic [1:0]                    pad_ctrl;

    apb_decoder decoder (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp),
        .reg_wr(reg_wr),
        .status_rd(status_rd),
        .product(product),
        .pad_bit(pad_bit),
        .flash_rd(flash_rd)
    );

    periph_regs regs (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .reg_wr(reg_wr),
        .status_rd(status_rd),
        .leds(leds),
        .pad_ctrl(pad_ctrl),
        .flash_pins(flash_pins),
        .flash_io_in(flash_io_in),
        .flash_rd(flash_rd)
    );

    dsp_mult mult (
        .vdp_clk(vdp_clk),
        .reg_wr(reg_wr),
        .product(product)
    );

    pad_shifter pad (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .pad_ctrl(pad_ctrl),
        .buttons(buttons),
        .pad_bit(pad_bit)
    );

endmodule

`default_nettype wire

// ==== design/pad_shifter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Gamepad button latch and serial shift
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module pad_shifter (
    input  logic                 vdp_clk,
    input  logic                 vdp_reset,
    input  logic [1:0]           pad_ctrl,
    input  periph_pkg::buttons_t buttons,
    output logic                 pad_bit
);

    logic                         pad_latch;
    logic                         pad_clk;
    logic                         pad_clk_r;
    logic                         clk_rise;
    logic [periph_pkg::pad_w-1:0] load_val;
    logic [periph_pkg::pad_w-1:0] state;

    assign pad_latch = pad_ctrl[0];
    assign pad_clk = pad_ctrl[1];
    assign clk_rise = pad_clk && !pad_clk_r;

    // Board buttons stand in for left, right and B
    assign load_val = {{(periph_pkg::pad_w-8){1'b0}},
                       buttons.btn_1, buttons.btn_3, 5'b0, buttons.btn_2};

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state <= '0;
            pad_clk_r <= 1'b0;
        end else begin
            pad_clk_r <= pad_clk;
            // Shift wins over a load in the same cycle
            if (clk_rise) begin
                state <= {1'b0, state[periph_pkg::pad_w-1:1]};
            end else if (pad_latch) begin
                state <= load_val;
            end
        end
    end

    assign pad_bit = state[0];

endmodule

`default_nettype wire

// ==== design/dsp_mult.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Signed 16x16 multiplier with registered product
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module dsp_mult (
    input  logic                          vdp_clk,
    input  periph_pkg::reg_wr_t           reg_wr,
    output logic [periph_pkg::data_w-1:0] product
);

    logic               wr_a;
    logic               wr_b;
    logic signed [15:0] mult_a;
    logic signed [15:0] mult_b;
    logic signed [31:0] product_q;

    assign wr_a = reg_wr.valid && (reg_wr.sel == periph_pkg::sel_mult_a);
    assign wr_b = reg_wr.valid && (reg_wr.sel == periph_pkg::sel_mult_b);

    // Flat enables so the operands map onto the DSP input registers
    always_ff @(posedge vdp_clk) begin
        if (wr_a) begin
            mult_a <= reg_wr.data[15:0];
        end
        if (wr_b) begin
            mult_b <= reg_wr.data[15:0];
        end
        product_q <= mult_a * mult_b;
    end

    assign product = product_q;

endmodule

`default_nettype wire

// ==== design/periph_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Status, gamepad control and flash control regs
// Flash pin drive and flash input sample
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module periph_regs (
    input  logic                    vdp_clk,
    input  logic                    vdp_reset,
    input  periph_pkg::reg_wr_t     reg_wr,
    output logic [1:0]              status_rd,
    output logic [1:0]              leds,
    output logic [1:0]              pad_ctrl,
    output periph_pkg::flash_pins_t flash_pins,
    input  logic [3:0]              flash_io_in,
    output logic [3:0]              flash_rd
);

    logic                    wr_status;
    logic                    wr_pad;
    logic                    wr_flash;
    logic [1:0]              status_q;
    logic [1:0]              pad_ctrl_q;
    logic                    flash_active;
    periph_pkg::flash_pins_t flash_manual;
    logic [3:0]              flash_in_q;

    assign wr_status = reg_wr.valid && (reg_wr.sel == periph_pkg::sel_status);
    assign wr_pad = reg_wr.valid && (reg_wr.sel == periph_pkg::sel_pad);
    assign wr_flash = reg_wr.valid && (reg_wr.sel == periph_pkg::sel_flash);

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status_q <= periph_pkg::status_reset;
            pad_ctrl_q <= 2'b00;
            flash_active <= 1'b0;
        end else begin
            if (wr_status) begin
                status_q <= reg_wr.data[1:0];
            end
            // Bit 0 latch, bit 1 pad clock
            if (wr_pad) begin
                pad_ctrl_q <= reg_wr.data[1:0];
            end
            if (wr_flash) begin
                flash_active <= reg_wr.data[15];
            end
        end
    end

    // Manual pin state only visible while active
    always_ff @(posedge vdp_clk) begin
        if (wr_flash) begin
            flash_manual.io_out <= reg_wr.data[3:0];
            flash_manual.io_oe <= reg_wr.data[7:4];
            flash_manual.clk <= reg_wr.data[8];
            flash_manual.csn <= reg_wr.data[9];
        end
    end

    always_ff @(posedge vdp_clk) begin
        flash_in_q <= flash_io_in;
    end

    assign flash_pins = flash_active ? flash_manual : periph_pkg::flash_idle;
    assign flash_rd = flash_in_q;

    // Red on bit 0, blue on bit 1
    assign leds = status_q;
    assign status_rd = status_q;
    assign pad_ctrl = pad_ctrl_q;

endmodule

`default_nettype wire

// ==== design/apb_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave for the peripheral block
// Word decode, single wait state, write strobe
// and registered read data return
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module apb_decoder (
    input  logic                               vdp_clk,
    input  logic                               vdp_reset,
    input  periph_pkg::apb_req_t               apb_req,
    output periph_pkg::apb_rsp_t               apb_rsp,
    output periph_pkg::reg_wr_t                reg_wr,
    input  logic [1:0]                         status_rd,
    input  logic [periph_pkg::data_w-1:0]      product,
    input  logic                               pad_bit,
    input  logic [3:0]                         flash_rd
);

    logic [periph_pkg::word_w-1:0] word_addr;
    periph_pkg::reg_sel_e          sel;
    logic [periph_pkg::data_w-1:0] rd_mux;
    logic [periph_pkg::data_w-1:0] prdata_q;
    logic                          pready_q;
    logic                          pslverr_q;
    logic                          wr_valid_q;
    logic                          access_first;

    assign word_addr = apb_req.paddr[periph_pkg::addr_w-1:2];

    always_comb begin
        case (word_addr)
            6'd0:    sel = periph_pkg::sel_status;
            6'd1:    sel = periph_pkg::sel_mult_a;
            6'd2:    sel = periph_pkg::sel_mult_b;
            6'd3:    sel = periph_pkg::sel_pad;
            6'd4:    sel = periph_pkg::sel_flash;
            default: sel = periph_pkg::sel_none;
        endcase
    end

    // Unmapped words read as zero
    always_comb begin
        case (sel)
            periph_pkg::sel_status: rd_mux = {{(periph_pkg::data_w-2){1'b0}}, status_rd};
            periph_pkg::sel_mult_a,
            periph_pkg::sel_mult_b: rd_mux = product;
            periph_pkg::sel_pad:    rd_mux = {{(periph_pkg::data_w-2){1'b0}}, 1'b0, pad_bit};
            periph_pkg::sel_flash:  rd_mux = {{(periph_pkg::data_w-4){1'b0}}, flash_rd};
            default:                rd_mux = '0;
        endcase
    end

    // First access cycle, this is the wait state
    assign access_first = apb_req.psel && apb_req.penable && !pready_q;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pready_q <= 1'b0;
            pslverr_q <= 1'b0;
            wr_valid_q <= 1'b0;
        end else begin
            pready_q <= access_first;
            pslverr_q <= access_first && (sel == periph_pkg::sel_none);
            wr_valid_q <= access_first && apb_req.pwrite && (sel != periph_pkg::sel_none);
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (access_first) begin
            prdata_q <= rd_mux;
        end
    end

    assign apb_rsp = '{prdata: prdata_q, pready: pready_q, pslverr: pslverr_q};

    // Strobe lines up with pready, master holds pwdata and paddr
    assign reg_wr.valid = wr_valid_q;
    assign reg_wr.sel = sel;
    assign reg_wr.data = apb_req.pwdata;

    penable_needs_psel: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset)
        apb_req.penable |-> apb_req.psel
    );

    // Master must hold the request through the wait state
    req_stable_in_wait: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset)
        (apb_req.psel && apb_req.penable && !pready_q) |=>
            (apb_req.psel && apb_req.penable && $stable(apb_req.paddr) &&
             $stable(apb_req.pwrite) && $stable(apb_req.pwdata))
    );

endmodule

`default_nettype wire

// ==== design/periph_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral block shared definitions
// Address map, bus widths, register select enum
// APB, register write, flash pin and button structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package periph_pkg;

    // Bus widths
    localparam int data_w = 32;
    localparam int addr_w = 8;

    // Word address, byte offset bits dropped
    localparam int word_w = addr_w - 2;

    // Gamepad shift state
    localparam int pad_w = 16;

    // LED state out of reset, red on
    localparam logic [1:0] status_reset = 2'b01;

    // Target register from the word address
    typedef enum logic [2:0] {
        sel_status = 3'd0,
        sel_mult_a = 3'd1,
        sel_mult_b = 3'd2,
        sel_pad    = 3'd3,
        sel_flash  = 3'd4,
        sel_none   = 3'd7
    } reg_sel_e;

    typedef struct packed {
        logic [addr_w-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [data_w-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [data_w-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // One register write, valid for a single cycle
    typedef struct packed {
        logic              valid;
        reg_sel_e          sel;
        logic [data_w-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic       clk;
        logic       csn;
        logic [3:0] io_out;
        logic [3:0] io_oe;
    } flash_pins_t;

    typedef struct packed {
        logic btn_1;
        logic btn_2;
        logic btn_3;
    } buttons_t;

    // Flash pins while manual mode is off
    localparam flash_pins_t flash_idle = '{clk: 1'b0, csn: 1'b1, io_out: 4'b0, io_oe: 4'b0};

endpackage

`default_nettype wire
